// File: ieu_pkg.sv
package ieu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int TAG_WIDTH  = 6;

    // RV32I major opcodes handled by the integer lanes.
    typedef enum logic [6:0] {
        OPCODE_OP    = 7'b0110011,
        OPCODE_OPIMM = 7'b0010011,
        OPCODE_LUI   = 7'b0110111,
        OPCODE_AUIPC = 7'b0010111
    } opcode_e;

    // Encodings of insn[14:12] for OP and OP-IMM.
    typedef enum logic [2:0] {
        FUNCT3_ADD  = 3'b000,
        FUNCT3_SLL  = 3'b001,
        FUNCT3_SLT  = 3'b010,
        FUNCT3_SLTU = 3'b011,
        FUNCT3_XOR  = 3'b100,
        FUNCT3_SR   = 3'b101,
        FUNCT3_OR   = 3'b110,
        FUNCT3_AND  = 3'b111
    } funct3_e;

    // Internal ALU function codes.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        opcode_e                       opcode;
        logic [ADDR_WIDTH-1:0]         iaddr;
        logic [31:0]                   insn;
        logic [1:0]                    src_rdy;
        logic [1:0][DATA_WIDTH-1:0]    src_data;
        logic [1:0][TAG_WIDTH-1:0]     src_tag;
        logic [TAG_WIDTH-1:0]          dst_tag;
    } rs_dispatch_t;

    // Operands fully resolved.
    typedef struct packed {
        opcode_e                       opcode;
        logic [ADDR_WIDTH-1:0]         iaddr;
        logic [31:0]                   insn;
        logic [1:0][DATA_WIDTH-1:0]    src_data;
        logic [TAG_WIDTH-1:0]          dst_tag;
    } issue_t;

    typedef struct packed {
        logic                          valid;
        logic [TAG_WIDTH-1:0]          tag;
        logic [DATA_WIDTH-1:0]         data;
    } cdb_pkt_t;

endpackage

// File: sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T           = logic,
    parameter int  DEPTH       = 4,
    parameter int  FULL_MARGIN = 0
) (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_flush,
    input  logic i_push,
    input  T     i_data,
    output logic o_full,
    input  logic i_pop,
    output logic o_valid,
    output T     o_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Full is raised FULL_MARGIN places early.
    assign o_full  = (count >= CNT_W'(DEPTH - FULL_MARGIN));
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(i_push) - CNT_W'(i_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Callers must respect the occupancy they are given.
    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_push && count == CNT_W'(DEPTH)));
    a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_pop && !o_valid));

endmodule

// File: rs_issue.sv
`timescale 1ns/1ps

module rs_issue #(
    parameter int NUM_LANES = 2,
    parameter int RS_DEPTH  = 8
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,
    input  logic                  i_in_valid,
    input  ieu_pkg::rs_dispatch_t i_in,
    output logic                  o_in_pop,
    input  ieu_pkg::cdb_pkt_t     i_cdb,
    input  logic [NUM_LANES-1:0]  i_lane_ready,
    output logic [NUM_LANES-1:0]  o_issue_valid,
    output ieu_pkg::issue_t       o_issue
);

    import ieu_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    // Age counts the younger valid slots, so the oldest has the largest.
    logic [RS_DEPTH-1:0] slot_valid;
    logic [IDX_W-1:0]    slot_age [RS_DEPTH];
    rs_dispatch_t        slot_uop [RS_DEPTH];

    logic                free_found;
    logic [IDX_W-1:0]    free_idx;
    logic                iss_found;
    logic [IDX_W-1:0]    iss_idx;
    logic [IDX_W-1:0]    iss_age;
    logic                issue_fire;
    rs_dispatch_t        in_woken;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Capture side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!slot_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    assign o_in_pop = i_in_valid && free_found;

    // Catch a broadcast in the same cycle as capture.
    always_comb begin
        in_woken = i_in;
        for (int s = 0; s < 2; s++) begin
            if (!i_in.src_rdy[s] && i_cdb.valid && i_cdb.tag == i_in.src_tag[s]) begin
                in_woken.src_rdy[s]  = 1'b1;
                in_woken.src_data[s] = i_cdb.data;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        iss_found = 1'b0;
        iss_idx   = '0;
        iss_age   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (slot_valid[i] && (&slot_uop[i].src_rdy)
                    && (!iss_found || slot_age[i] > iss_age)) begin
                iss_found = 1'b1;
                iss_idx   = IDX_W'(i);
                iss_age   = slot_age[i];
            end
        end
    end

    // Lowest ready lane wins.
    always_comb begin
        o_issue_valid = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (iss_found && i_lane_ready[l] && o_issue_valid == '0) begin
                o_issue_valid[l] = 1'b1;
            end
        end
    end

    assign issue_fire = |o_issue_valid;

    always_comb begin
        o_issue.opcode   = slot_uop[iss_idx].opcode;
        o_issue.iaddr    = slot_uop[iss_idx].iaddr;
        o_issue.insn     = slot_uop[iss_idx].insn;
        o_issue.src_data = slot_uop[iss_idx].src_data;
        o_issue.dst_tag  = slot_uop[iss_idx].dst_tag;
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            slot_valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                slot_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (issue_fire && IDX_W'(i) == iss_idx) begin
                    slot_valid[i] <= 1'b0;
                end else if (slot_valid[i]) begin
                    if (o_in_pop && !(issue_fire && slot_age[i] > iss_age)) begin
                        slot_age[i] <= slot_age[i] + 1'b1;
                    end else if (!o_in_pop && issue_fire && slot_age[i] > iss_age) begin
                        slot_age[i] <= slot_age[i] - 1'b1;
                    end
                end
            end
            if (o_in_pop) begin
                slot_valid[free_idx] <= 1'b1;
                slot_age[free_idx]   <= '0;
            end
        end
    end

    // Wake-up by tag, then capture into the free slot.
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (slot_valid[i] && !slot_uop[i].src_rdy[s] && i_cdb.valid
                        && i_cdb.tag == slot_uop[i].src_tag[s]) begin
                    slot_uop[i].src_rdy[s]  <= 1'b1;
                    slot_uop[i].src_data[s] <= i_cdb.data;
                end
            end
        end
        if (o_in_pop) begin
            slot_uop[free_idx] <= in_woken;
        end
    end

    // Ages of the valid slots stay below their count.
    a_issue_age: assert property (@(posedge clk) disable iff (!i_rst_n)
        issue_fire |-> int'(slot_age[iss_idx]) < $countones(slot_valid));

endmodule

// File: ieu_lane.sv
`timescale 1ns/1ps

module ieu_lane #(
    parameter int IEU_FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_flush,
    input  logic              i_issue_valid,
    input  ieu_pkg::issue_t   i_issue,
    output logic              o_ready,
    input  logic              i_res_pop,
    output logic              o_res_valid,
    output ieu_pkg::cdb_pkt_t o_res
);

    import ieu_pkg::*;

    funct3_e               funct3;
    logic [6:0]            funct7;
    logic [DATA_WIDTH-1:0] imm_i;
    logic [DATA_WIDTH-1:0] imm_u;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    logic [4:0]            shamt;
    alu_op_e               alu_op;
    logic [DATA_WIDTH-1:0] result;
    cdb_pkt_t              stage;
    logic                  fifo_afull;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign funct3 = funct3_e'(i_issue.insn[14:12]);
    assign funct7 = i_issue.insn[31:25];
    assign imm_i  = {{20{i_issue.insn[31]}}, i_issue.insn[31:20]};
    assign imm_u  = {i_issue.insn[31:12], 12'b0};
    assign op_a   = i_issue.src_data[0];
    assign op_b   = (i_issue.opcode == OPCODE_OP) ? i_issue.src_data[1] : imm_i;
    assign shamt  = op_b[4:0];

    always_comb begin
        case (funct3)
            // SUB only exists in register form.
            FUNCT3_ADD: alu_op = (i_issue.opcode == OPCODE_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL:  alu_op = ALU_SLL;
            FUNCT3_SLT:  alu_op = ALU_SLT;
            FUNCT3_SLTU: alu_op = ALU_SLTU;
            FUNCT3_XOR:  alu_op = ALU_XOR;
            FUNCT3_SR:   alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:   alu_op = ALU_OR;
            default:     alu_op = ALU_AND;
        endcase
        if (i_issue.opcode == OPCODE_LUI) begin
            alu_op = ALU_LUI;
        end else if (i_issue.opcode == OPCODE_AUIPC) begin
            alu_op = ALU_AUIPC;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compute.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (alu_op)
            ALU_ADD:   result = op_a + op_b;
            ALU_SUB:   result = op_a - op_b;
            ALU_SLL:   result = op_a << shamt;
            ALU_SLT:   result = {{(DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  result = {{(DATA_WIDTH-1){1'b0}}, op_a < op_b};
            ALU_XOR:   result = op_a ^ op_b;
            ALU_SRL:   result = op_a >> shamt;
            ALU_SRA:   result = $signed(op_a) >>> shamt;
            ALU_OR:    result = op_a | op_b;
            ALU_AND:   result = op_a & op_b;
            ALU_LUI:   result = imm_u;
            ALU_AUIPC: result = i_issue.iaddr + imm_u;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= i_issue_valid;
            stage.tag   <= i_issue.dst_tag;
            stage.data  <= result;
        end
    end

    // Two free places cover the staged op plus the one issuing now.
    sync_fifo #(
        .T          (cdb_pkt_t),
        .DEPTH      (IEU_FIFO_DEPTH),
        .FULL_MARGIN(1)
    ) res_fifo_i (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_flush(i_flush),
        .i_push (stage.valid),
        .i_data (stage),
        .o_full (fifo_afull),
        .i_pop  (i_res_pop),
        .o_valid(o_res_valid),
        .o_data (o_res)
    );

    assign o_ready = !fifo_afull;

    a_issue_when_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_issue_valid |-> o_ready);

endmodule

// File: cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int NUM_LANES = 2
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic [NUM_LANES-1:0] i_res_valid,
    input  ieu_pkg::cdb_pkt_t    i_res [NUM_LANES],
    output logic [NUM_LANES-1:0] o_res_pop,
    output ieu_pkg::cdb_pkt_t    o_cdb
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] rr_ptr;
    logic [PTR_W-1:0] gnt_idx;
    logic             gnt_found;

    // Search starts at the lane after the last winner.
    always_comb begin
        int idx;
        gnt_found = 1'b0;
        gnt_idx   = '0;
        o_res_pop = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_LANES;
            if (!gnt_found && i_res_valid[idx]) begin
                gnt_found      = 1'b1;
                gnt_idx        = PTR_W'(idx);
                o_res_pop[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            o_cdb.valid <= 1'b0;
            rr_ptr      <= '0;
        end else begin
            o_cdb.valid <= gnt_found;
            o_cdb.tag   <= i_res[gnt_idx].tag;
            o_cdb.data  <= i_res[gnt_idx].data;
            if (gnt_found) begin
                rr_ptr <= (gnt_idx == PTR_W'(NUM_LANES - 1)) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

    // A lane that just won yields to any other lane left waiting.
    a_rr_fair: assert property (@(posedge clk) disable iff (!i_rst_n)
        ((o_res_pop != '0) && ((i_res_valid & ~o_res_pop) != '0))
            |=> ((o_res_pop & $past(o_res_pop)) == '0));

endmodule

// File: ieu_cluster.sv
`timescale 1ns/1ps

module ieu_cluster #(
    parameter int NUM_LANES      = 2,
    parameter int RS_DEPTH       = 8,
    parameter int IN_FIFO_DEPTH  = 4,
    parameter int IEU_FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,
    input  logic                  i_dispatch_valid,
    input  ieu_pkg::rs_dispatch_t i_dispatch,
    output logic                  o_dispatch_ready,
    output ieu_pkg::cdb_pkt_t     o_cdb
);

    import ieu_pkg::*;

    logic                 in_full;
    logic                 in_valid;
    logic                 in_pop;
    rs_dispatch_t         in_head;
    logic [NUM_LANES-1:0] lane_ready;
    logic [NUM_LANES-1:0] issue_valid;
    issue_t               issue;
    logic [NUM_LANES-1:0] res_valid;
    logic [NUM_LANES-1:0] res_pop;
    cdb_pkt_t             res [NUM_LANES];
    cdb_pkt_t             cdb;

    assign o_dispatch_ready = !in_full;
    assign o_cdb            = cdb;

    sync_fifo #(
        .T    (rs_dispatch_t),
        .DEPTH(IN_FIFO_DEPTH)
    ) in_fifo_i (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_flush(i_flush),
        .i_push (i_dispatch_valid && !in_full),
        .i_data (i_dispatch),
        .o_full (in_full),
        .i_pop  (in_pop),
        .o_valid(in_valid),
        .o_data (in_head)
    );

    rs_issue #(
        .NUM_LANES(NUM_LANES),
        .RS_DEPTH (RS_DEPTH)
    ) rs_issue_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_flush),
        .i_in_valid   (in_valid),
        .i_in         (in_head),
        .o_in_pop     (in_pop),
        .i_cdb        (cdb),
        .i_lane_ready (lane_ready),
        .o_issue_valid(issue_valid),
        .o_issue      (issue)
    );

    // All lanes share the issue bus; the valid bit picks one.
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        ieu_lane #(
            .IEU_FIFO_DEPTH(IEU_FIFO_DEPTH)
        ) ieu_lane_i (
            .clk          (clk),
            .i_rst_n      (i_rst_n),
            .i_flush      (i_flush),
            .i_issue_valid(issue_valid[l]),
            .i_issue      (issue),
            .o_ready      (lane_ready[l]),
            .i_res_pop    (res_pop[l]),
            .o_res_valid  (res_valid[l]),
            .o_res        (res[l])
        );
    end

    cdb_arbiter #(
        .NUM_LANES(NUM_LANES)
    ) cdb_arbiter_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_res_valid(res_valid),
        .i_res      (res),
        .o_res_pop  (res_pop),
        .o_cdb      (cdb)
    );

endmodule

// File: ieu_cluster_tb.sv
`timescale 1ns/1ps

module ieu_cluster_tb;

    import ieu_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int NUM_TAGS        = 2 ** TAG_WIDTH;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         dispatch_valid;
    rs_dispatch_t dispatch;
    logic         dispatch_ready;
    cdb_pkt_t     cdb;

    // Scoreboard indexed by tag.
    cdb_pkt_t             exp_pkt     [NUM_TAGS];
    string                exp_name    [NUM_TAGS];
    bit                   exp_pending [NUM_TAGS];
    time                  seen_at     [NUM_TAGS];
    int                   outstanding = 0;
    int                   err_cnt     = 0;
    int                   check_cnt   = 0;
    logic [TAG_WIDTH-1:0] next_tag    = '0;
    logic [31:0]          lfsr_state  = 32'h0fff_d0fd;
    bit                   ready_low_seen;

    ieu_cluster ieu_cluster_i (
        .clk             (clk),
        .i_rst_n         (rst_n),
        .i_flush         (flush),
        .i_dispatch_valid(dispatch_valid),
        .i_dispatch      (dispatch),
        .o_dispatch_ready(dispatch_ready),
        .o_cdb           (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] rand_word(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [TAG_WIDTH-1:0] alloc_tag();
        logic [TAG_WIDTH-1:0] t;
        t        = next_tag;
        next_tag = next_tag + 1'b1;
        return t;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, OPCODE_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, OPCODE_OPIMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input opcode_e op);
        return {imm, 5'd3, op};
    endfunction

    // Reference ALU built from the RV32I rules.
    function automatic logic [31:0] model_alu(input opcode_e op, input logic [31:0] pc,
                                              input logic [31:0] insn, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] rhs;
        logic [31:0] imm_u;
        logic [4:0]  sh;
        imm_u = {insn[31:12], 12'h000};
        rhs   = (op == OPCODE_OP) ? b : {{20{insn[31]}}, insn[31:20]};
        sh    = rhs[4:0];
        if (op == OPCODE_LUI) begin
            return imm_u;
        end
        if (op == OPCODE_AUIPC) begin
            return pc + imm_u;
        end
        case (insn[14:12])
            3'b000: return (op == OPCODE_OP && insn[30]) ? a - rhs : a + rhs;
            3'b001: return a << sh;
            3'b010: return ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
            3'b011: return (a < rhs) ? 32'd1 : 32'd0;
            3'b100: return a ^ rhs;
            3'b101: begin
                if (insn[30]) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'b110: return a | rhs;
            default: return a & rhs;
        endcase
    endfunction

    function automatic rs_dispatch_t make_uop(input opcode_e op, input logic [31:0] pc,
            input logic [31:0] insn, input logic [31:0] a, input logic [31:0] b,
            input logic [1:0] rdy, input logic [TAG_WIDTH-1:0] tag_a,
            input logic [TAG_WIDTH-1:0] tag_b, input logic [TAG_WIDTH-1:0] dst);
        rs_dispatch_t u;
        u.opcode      = op;
        u.iaddr       = pc;
        u.insn        = insn;
        u.src_rdy     = rdy;
        u.src_data[0] = a;
        u.src_data[1] = b;
        u.src_tag[0]  = tag_a;
        u.src_tag[1]  = tag_b;
        u.dst_tag     = dst;
        return u;
    endfunction

    task automatic check_cdb(input string name, input cdb_pkt_t exp, input cdb_pkt_t act);
        check_cnt++;
        if (exp.tag !== act.tag || exp.data !== act.data) begin
            err_cnt++;
            $display("[ERROR] %s: expected tag %0d data %08h, actual tag %0d data %08h",
                     name, exp.tag, exp.data, act.tag, act.data);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // Results are sampled away from the clock edge.
    always @(negedge clk) begin
        if (rst_n && cdb.valid === 1'b1) begin
            if (!exp_pending[cdb.tag]) begin
                err_cnt++;
                $display("Unexpected result on the CDB for tag %0d at %0t.", cdb.tag, $time);
            end else begin
                check_cdb(exp_name[cdb.tag], exp_pkt[cdb.tag], cdb);
                exp_pending[cdb.tag] = 1'b0;
                seen_at[cdb.tag]     = $time;
                outstanding--;
            end
        end
    end

    // Entered and left 1 ns after a rising edge.
    task automatic send_uop(input string name, input rs_dispatch_t uop, input logic [31:0] data);
        logic accepted;
        exp_pkt[uop.dst_tag].valid = 1'b1;
        exp_pkt[uop.dst_tag].tag   = uop.dst_tag;
        exp_pkt[uop.dst_tag].data  = data;
        exp_name[uop.dst_tag]      = name;
        exp_pending[uop.dst_tag]   = 1'b1;
        outstanding++;
        dispatch       = uop;
        dispatch_valid = 1'b1;
        accepted       = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = dispatch_ready;
            if (!accepted) begin
                ready_low_seen = 1'b1;
            end
            @(posedge clk);
        end
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic run_ready_op(input string name, input opcode_e op, input logic [31:0] insn);
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          pc;
        logic [TAG_WIDTH-1:0] tag;
        a   = rand_word(32);
        b   = rand_word(32);
        pc  = {30'(rand_word(30)), 2'b00};
        tag = alloc_tag();
        send_uop(name, make_uop(op, pc, insn, a, b, 2'b11, '0, '0, tag),
                 model_alu(op, pc, insn, a, b));
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset();
        @(negedge clk);
        check_bit("reset cdb valid", 1'b0, cdb.valid);
        check_bit("reset dispatch ready", 1'b1, dispatch_ready);
        @(posedge clk);
        #1;
    endtask

    task automatic test_alu();
        logic [11:0] imm;
        for (int f3 = 0; f3 < 8; f3++) begin
            run_ready_op($sformatf("alu op f3=%0d", f3), OPCODE_OP, enc_r(7'h00, 3'(f3)));
        end
        run_ready_op("alu sub", OPCODE_OP, enc_r(7'h20, 3'b000));
        run_ready_op("alu sra", OPCODE_OP, enc_r(7'h20, 3'b101));
        for (int f3 = 0; f3 < 8; f3++) begin
            imm = 12'(rand_word(12));
            // Shift immediates keep funct7 clear.
            if (f3 == 1 || f3 == 5) begin
                imm[11:5] = 7'h00;
            end
            run_ready_op($sformatf("alu opimm f3=%0d", f3), OPCODE_OPIMM, enc_i(imm, 3'(f3)));
        end
        run_ready_op("alu srai", OPCODE_OPIMM, enc_i({7'h20, 5'(rand_word(5))}, 3'b101));
        run_ready_op("alu lui", OPCODE_LUI, enc_u(20'(rand_word(20)), OPCODE_LUI));
        run_ready_op("alu auipc", OPCODE_AUIPC, enc_u(20'(rand_word(20)), OPCODE_AUIPC));
        wait_drain();
    endtask

    task automatic test_wakeup();
        logic [TAG_WIDTH-1:0] p;
        logic [TAG_WIDTH-1:0] c1;
        logic [TAG_WIDTH-1:0] c2;
        logic [31:0]          pa;
        logic [31:0]          pb;
        logic [31:0]          b1;
        logic [31:0]          p_res;
        logic [31:0]          c1_res;
        p     = alloc_tag();
        c1    = alloc_tag();
        c2    = alloc_tag();
        pa    = rand_word(32);
        pb    = rand_word(32);
        b1    = rand_word(32);
        p_res = model_alu(OPCODE_OP, 32'h0, enc_r(7'h00, 3'b000), pa, pb);
        send_uop("wakeup producer",
                 make_uop(OPCODE_OP, 32'h0, enc_r(7'h00, 3'b000), pa, pb, 2'b11, '0, '0, p),
                 p_res);
        c1_res = model_alu(OPCODE_OP, 32'h0, enc_r(7'h20, 3'b000), p_res, b1);
        send_uop("wakeup consumer one",
                 make_uop(OPCODE_OP, 32'h0, enc_r(7'h20, 3'b000), rand_word(32), b1,
                          2'b10, p, '0, c1),
                 c1_res);
        send_uop("wakeup consumer two",
                 make_uop(OPCODE_OP, 32'h0, enc_r(7'h00, 3'b100), rand_word(32),
                          rand_word(32), 2'b00, c1, p, c2),
                 model_alu(OPCODE_OP, 32'h0, enc_r(7'h00, 3'b100), c1_res, p_res));
        wait_drain();
        check_bit("wakeup consumer one after producer", 1'b1, seen_at[c1] > seen_at[p]);
        check_bit("wakeup consumer two after consumer one", 1'b1, seen_at[c2] > seen_at[c1]);
    endtask

    // A dependency chain keeps the station full.
    task automatic test_backpressure();
        logic [TAG_WIDTH-1:0] prev;
        logic [TAG_WIDTH-1:0] tag;
        logic [31:0]          prev_res;
        logic [31:0]          insn;
        logic [31:0]          a;
        ready_low_seen = 1'b0;
        a        = rand_word(32);
        insn     = enc_i(12'(rand_word(12)), 3'b000);
        prev     = alloc_tag();
        prev_res = model_alu(OPCODE_OPIMM, 32'h0, insn, a, 32'h0);
        send_uop("backpressure head",
                 make_uop(OPCODE_OPIMM, 32'h0, insn, a, 32'h0, 2'b11, '0, '0, prev), prev_res);
        for (int i = 1; i < 26; i++) begin
            insn     = enc_i(12'(rand_word(12)), (i % 2 == 0) ? 3'b000 : 3'b100);
            tag      = alloc_tag();
            send_uop($sformatf("backpressure chain %0d", i),
                     make_uop(OPCODE_OPIMM, 32'h0, insn, rand_word(32), 32'h0,
                              2'b10, prev, '0, tag),
                     model_alu(OPCODE_OPIMM, 32'h0, insn, prev_res, 32'h0));
            prev_res = model_alu(OPCODE_OPIMM, 32'h0, insn, prev_res, 32'h0);
            prev     = tag;
        end
        wait_drain();
        check_bit("backpressure dispatch ready fell", 1'b1, ready_low_seen);
    endtask

    task automatic test_flush();
        logic [TAG_WIDTH-1:0] phantom;
        logic [TAG_WIDTH-1:0] blocked [5];
        logic [TAG_WIDTH-1:0] in_flight;
        logic [31:0]          insn;
        phantom = alloc_tag();
        for (int i = 0; i < 5; i++) begin
            blocked[i] = alloc_tag();
            insn       = enc_i(12'(rand_word(12)), 3'b000);
            send_uop($sformatf("flush blocked %0d", i),
                     make_uop(OPCODE_OPIMM, 32'h0, insn, rand_word(32), 32'h0,
                              2'b10, phantom, '0, blocked[i]),
                     32'h0);
        end
        repeat (6) @(posedge clk);
        #1;
        // This op sits in a lane stage when the flush is sampled.
        in_flight = next_tag;
        run_ready_op("flush in flight", OPCODE_OP, enc_r(7'h00, 3'b000));
        repeat (2) @(posedge clk);
        #1;
        flush = 1'b1;
        for (int i = 0; i < 5; i++) begin
            exp_pending[blocked[i]] = 1'b0;
            outstanding--;
        end
        exp_pending[in_flight] = 1'b0;
        outstanding--;
        @(posedge clk);
        #1;
        flush = 1'b0;
        // The producer of the flushed sources now runs.
        tag_reuse_check: begin
            logic [31:0] a;
            logic [31:0] b;
            a = rand_word(32);
            b = rand_word(32);
            send_uop("flush producer",
                     make_uop(OPCODE_OP, 32'h0, enc_r(7'h00, 3'b110), a, b, 2'b11, '0, '0,
                              phantom),
                     model_alu(OPCODE_OP, 32'h0, enc_r(7'h00, 3'b110), a, b));
        end
        run_ready_op("flush after one", OPCODE_OP, enc_r(7'h00, 3'b111));
        run_ready_op("flush after two", OPCODE_LUI, enc_u(20'(rand_word(20)), OPCODE_LUI));
        wait_drain();
        repeat (30) @(posedge clk);
        @(negedge clk);
        check_bit("flush dispatch ready after drain", 1'b1, dispatch_ready);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequence and watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_wakeup();
        test_backpressure();
        test_flush();
        repeat (10) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST));
        $display("Watchdog expired with %0d results outstanding, errors so far: %0d",
                 outstanding, err_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
ieu_pkg.sv
sync_fifo.sv
rs_issue.sv
ieu_lane.sv
cdb_arbiter.sv
ieu_cluster.sv
ieu_cluster_tb.sv

// File: Bender.yml
package:
  name: ieu_cluster

sources:
  - ieu_pkg.sv
  - sync_fifo.sv
  - rs_issue.sv
  - ieu_lane.sv
  - cdb_arbiter.sv
  - ieu_cluster.sv
  - target: simulation
    files:
      - ieu_cluster_tb.sv
